// ==== hba_fsm_pkg.sv ====
// program word is 18 bits; a transition word with bit 17 set never matches and closes its phase
`default_nettype none

package hba_fsm_pkg;

    // action view of a program word
    typedef struct packed {
        logic       last;       // closes the action phase
        logic       wait_done;  // stall after the pulse until a done
        logic [9:0] spare;
        logic [5:0] act_code;   // 0 halts, 1..ACT_NUM pulse
    } act_word_t;

    // transition view of the same word
    typedef struct packed {
        logic [7:0] cond_sel;   // >= COND_NUM reads false
        logic [9:0] jump_addr;
    } trans_word_t;

    typedef union packed {
        act_word_t   act;
        trans_word_t trans;
    } pgm_word_u;

    localparam logic [5:0] ACT_HALT = 6'd0;
    localparam int         ACT_NUM  = 24;   // code 1 is the first member below

    typedef struct packed {
        logic syncesc_send;     // link
        logic comreset_send;
        logic set_offline;
        logic send_r_ok;
        logic send_r_err;
        logic get_rfis;         // fis receive
        logic get_dsfis;
        logic get_psfis;
        logic get_sdbfis;
        logic get_ufis;
        logic get_data_fis;
        logic get_ignore;
        logic fetch_cmd;        // fis transmit
        logic cfis_xmit;
        logic dx_xmit;
        logic atapi_xmit;
        logic pcmd_cr_set;      // status
        logic pcmd_cr_reset;
        logic pxci0_clear;
        logic sirq_dhr;
        logic sirq_tfe;
        logic sirq_if;
        logic clear_bsy_drq;
        logic set_bsy;
    } fsm_actions_t;

    typedef struct packed {
        logic xmit_done;
        logic get_fis_done;
        logic syncesc_send_done;
    } fsm_done_t;

    typedef struct packed {
        logic       pcmd_st;
        logic [7:0] tfd_sts;        // bit 7 bsy, bit 3 drq, bit 0 err
        logic       pxci0;
        logic       cmd_to_issue;
        logic       fis_first_vld;
        logic [7:0] fis_type;       // valid with fis_first_vld
        logic       fis_ok;
        logic       fis_err;
        logic       fis_ferr;
        logic       xfer_cntr_zero;
        logic       pio_xfer;
        logic       fis_i;
    } port_status_t;

    localparam int COND_NUM = 16;   // index 0 always true

    localparam logic [7:0] FIS_D2HR = 8'h34;
    localparam logic [7:0] FIS_SDB  = 8'ha1;
    localparam logic [7:0] FIS_DMAA = 8'h39;
    localparam logic [7:0] FIS_DMAS = 8'h41;
    localparam logic [7:0] FIS_PIOS = 8'h5f;
    localparam logic [7:0] FIS_DATA = 8'h46;

    // entry points widened to the program address width by users
    localparam logic [9:0] LABEL_POR        = 10'd0;
    localparam logic [9:0] LABEL_HBA_RST    = 10'd2;
    localparam logic [9:0] LABEL_PORT_RST   = 10'd4;
    localparam logic [9:0] LABEL_COMINIT    = 10'd6;
    localparam logic [9:0] LABEL_ST_CLEARED = 10'd8;

endpackage

`default_nettype wire

// ==== fsm_pgm_mem.sv ====
// write pointer has no reset, so software must load it with pgm_wa before the first pgm_wd
`timescale 1ns/10ps
`default_nettype none

module fsm_pgm_mem #(
    parameter int PGM_AW = 10
) (
    input  wire logic                  aclk,
    input  wire logic [17:0]           pgm_ad,     // address or data
    input  wire logic                  pgm_wa,     // load pointer
    input  wire logic                  pgm_wd,     // write and advance
    input  wire logic [PGM_AW-1:0]     rd_addr,
    input  wire logic                  rd_en,
    output hba_fsm_pkg::pgm_word_u     rd_word
);

    logic [17:0]       mem [2**PGM_AW];
    logic [PGM_AW-1:0] wr_ptr;

    initial begin
        for (int i = 0; i < 2**PGM_AW; i++) begin
            mem[i] = '0;               // zero words decode as halt
        end
    end

    always_ff @(posedge aclk) begin
        if (pgm_wa) begin
            wr_ptr <= pgm_ad[PGM_AW-1:0];
        end else if (pgm_wd) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
        if (pgm_wd) begin
            mem[wr_ptr] <= pgm_ad;     // pointer value before the increment
        end
    end

    always_ff @(posedge aclk) begin
        if (rd_en) begin
            rd_word <= mem[rd_addr];   // held while rd_en low
        end
    end

endmodule

`default_nettype wire

// ==== fsm_cond_select.sv ====
// combinational; status must be stable in the cycle the transition word sits on rd_word
`timescale 1ns/10ps
`default_nettype none

module fsm_cond_select (
    input  wire hba_fsm_pkg::port_status_t status,
    input  wire logic [7:0]                cond_sel,
    output logic                           cond_met
);

    localparam int SEL_W = $clog2(hba_fsm_pkg::COND_NUM);

    logic [hba_fsm_pkg::COND_NUM-1:0] cond_vec;
    logic                             tfd_bsy;
    logic                             tfd_drq;
    logic                             tfd_err;
    logic                             type_d2hr;
    logic                             type_sdb;
    logic                             type_dmas;
    logic                             type_pios;
    logic                             type_data;

    assign tfd_bsy   = status.tfd_sts[7];
    assign tfd_drq   = status.tfd_sts[3];
    assign tfd_err   = status.tfd_sts[0];
    assign type_d2hr = (status.fis_type == hba_fsm_pkg::FIS_D2HR);
    assign type_sdb  = (status.fis_type == hba_fsm_pkg::FIS_SDB);
    assign type_dmas = (status.fis_type == hba_fsm_pkg::FIS_DMAS);
    assign type_pios = (status.fis_type == hba_fsm_pkg::FIS_PIOS);
    assign type_data = (status.fis_type == hba_fsm_pkg::FIS_DATA);

    assign cond_vec[0]  = 1'b1;                                   // unconditional
    assign cond_vec[1]  = status.pcmd_st && !tfd_bsy && !tfd_drq;
    assign cond_vec[2]  = status.pxci0 && !status.cmd_to_issue;   // nothing left to issue
    assign cond_vec[3]  = status.fis_first_vld && type_d2hr;
    assign cond_vec[4]  = status.fis_first_vld && type_data;
    assign cond_vec[5]  = status.fis_first_vld;                   // any fis head
    assign cond_vec[6]  = status.fis_ok;
    assign cond_vec[7]  = status.fis_err;
    assign cond_vec[8]  = status.fis_ferr;
    assign cond_vec[9]  = type_sdb;
    assign cond_vec[10] = type_dmas;
    assign cond_vec[11] = type_pios;
    assign cond_vec[12] = tfd_err;
    assign cond_vec[13] = status.xfer_cntr_zero;
    assign cond_vec[14] = status.pio_xfer && status.xfer_cntr_zero;
    assign cond_vec[15] = status.fis_i;

    // out of range selects never match
    assign cond_met = (cond_sel < 8'(hba_fsm_pkg::COND_NUM)) && cond_vec[cond_sel[SEL_W-1:0]];

endmodule

`default_nettype wire

// ==== fsm_action_decode.sv ====
// pulses are one cycle wide and lag act_strobe by one cycle; unknown codes produce nothing
`timescale 1ns/10ps
`default_nettype none

module fsm_action_decode (
    input  wire logic                 aclk,
    input  wire logic                 hba_rst,
    input  wire logic                 act_strobe,
    input  wire logic [5:0]           act_code,
    output hba_fsm_pkg::fsm_actions_t actions
);

    logic [hba_fsm_pkg::ACT_NUM-1:0] onehot;

    // code 1 lands on the msb which holds the first struct member
    always_comb begin
        for (int i = 0; i < hba_fsm_pkg::ACT_NUM; i++) begin
            onehot[i] = (act_code == 6'(hba_fsm_pkg::ACT_NUM - i));
        end
    end

    always_ff @(posedge aclk) begin
        if (hba_rst) begin
            actions <= '0;
        end else if (act_strobe) begin
            actions <= hba_fsm_pkg::fsm_actions_t'(onehot);   // zero above ACT_NUM
        end else begin
            actions <= '0;                                    // single cycle pulses
        end
    end

endmodule

`default_nettype wire

// ==== fsm_sequencer.sv ====
// a pending async request wins over the action word on rd_word, which is then not issued
`timescale 1ns/10ps
`default_nettype none

module fsm_sequencer #(
    parameter int PGM_AW = 10
) (
    input  wire logic                  aclk,
    input  wire logic                  hba_rst,
    input  wire logic                  was_hba_rst,
    input  wire logic                  was_port_rst,
    input  wire logic                  cominit_got,
    input  wire logic                  pcmd_st_cleared,
    input  wire hba_fsm_pkg::fsm_done_t done,
    input  wire hba_fsm_pkg::pgm_word_u rd_word,
    input  wire logic                  cond_met,
    output logic [PGM_AW-1:0]          rd_addr,
    output logic                       rd_en,
    output logic                       act_strobe,
    output logic [5:0]                 act_code
);

    localparam logic [2:0] S_JUMP    = 3'd0;  // load entry label
    localparam logic [2:0] S_PRELOAD = 3'd1;  // first read after a jump
    localparam logic [2:0] S_ACTION  = 3'd2;
    localparam logic [2:0] S_WAIT    = 3'd3;
    localparam logic [2:0] S_TRANS   = 3'd4;
    localparam logic [2:0] S_HALT    = 3'd5;

    logic [2:0]        state;
    logic [2:0]        state_nxt;
    logic [PGM_AW-1:0] pc;           // address of the next word to read
    logic [PGM_AW-1:0] pc_nxt;
    logic [PGM_AW-1:0] trans_base;   // first transition word of the phase
    logic              base_ld;
    logic              wait_last;    // waited word also closes the actions
    logic              async_pend;
    logic              async_st;     // high selects the st_cleared label
    logic              async_take;
    logic [PGM_AW-1:0] entry_label;
    logic [PGM_AW-1:0] async_label;

    assign entry_label = was_hba_rst  ? PGM_AW'(hba_fsm_pkg::LABEL_HBA_RST)  :
                         was_port_rst ? PGM_AW'(hba_fsm_pkg::LABEL_PORT_RST) :
                                        PGM_AW'(hba_fsm_pkg::LABEL_POR);
    assign async_label = async_st ? PGM_AW'(hba_fsm_pkg::LABEL_ST_CLEARED) :
                                    PGM_AW'(hba_fsm_pkg::LABEL_COMINIT);

    // taken once a word sits on rd_word or the sequencer is parked
    assign async_take = async_pend && (state != S_JUMP) && (state != S_PRELOAD);

    assign act_code   = rd_word.act.act_code;
    assign act_strobe = (state == S_ACTION) && !async_pend &&
                        (rd_word.act.act_code != hba_fsm_pkg::ACT_HALT);

    always_comb begin
        state_nxt = state;
        pc_nxt    = pc;
        rd_addr   = pc;
        rd_en     = 1'b0;
        base_ld   = 1'b0;
        if (async_take) begin
            pc_nxt    = async_label;   // same path as any jump
            state_nxt = S_PRELOAD;
        end else begin
            case (state)
                S_JUMP: begin
                    pc_nxt    = entry_label;
                    state_nxt = S_PRELOAD;
                end
                S_PRELOAD: begin
                    rd_en     = 1'b1;
                    pc_nxt    = pc + 1'b1;
                    state_nxt = S_ACTION;
                end
                S_ACTION: begin
                    if (rd_word.act.act_code == hba_fsm_pkg::ACT_HALT) begin
                        state_nxt = S_HALT;
                    end else if (rd_word.act.wait_done) begin
                        state_nxt = S_WAIT;        // no read until done
                    end else begin
                        rd_en  = 1'b1;
                        pc_nxt = pc + 1'b1;
                        if (rd_word.act.last) begin
                            base_ld   = 1'b1;      // word being read opens transitions
                            state_nxt = S_TRANS;
                        end
                    end
                end
                S_WAIT: begin
                    if (|done) begin
                        rd_en  = 1'b1;
                        pc_nxt = pc + 1'b1;
                        if (wait_last) begin
                            base_ld   = 1'b1;
                            state_nxt = S_TRANS;
                        end else begin
                            state_nxt = S_ACTION;
                        end
                    end
                end
                S_TRANS: begin
                    if (cond_met) begin
                        pc_nxt    = PGM_AW'(rd_word.trans.jump_addr);
                        state_nxt = S_PRELOAD;
                    end else if (rd_word.act.last) begin
                        rd_en   = 1'b1;            // wrap to the first transition
                        rd_addr = trans_base;
                        pc_nxt  = trans_base + 1'b1;
                    end else begin
                        rd_en  = 1'b1;
                        pc_nxt = pc + 1'b1;
                    end
                end
                default: begin
                    state_nxt = S_HALT;            // parked until async or reset
                end
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (hba_rst) begin
            state      <= S_JUMP;
            async_pend <= 1'b0;
            async_st   <= 1'b0;
            wait_last  <= 1'b0;
        end else begin
            state      <= state_nxt;
            async_pend <= (async_pend && !async_take) || cominit_got || pcmd_st_cleared;
            if (pcmd_st_cleared) begin
                async_st <= 1'b1;                  // st_cleared wins a tie
            end else if (cominit_got) begin
                async_st <= 1'b0;
            end
            if (state == S_ACTION) begin
                wait_last <= rd_word.act.last;
            end
        end
    end

    always_ff @(posedge aclk) begin
        pc <= pc_nxt;
        if (base_ld) begin
            trans_base <= pc;
        end
    end

endmodule

`default_nettype wire

// ==== ahci_port_fsm.sv ====
// program writes share aclk with the sequencer; only one port and one program image
`timescale 1ns/10ps
`default_nettype none

module ahci_port_fsm #(
    parameter int PGM_AW = 10
) (
    input  wire logic                      aclk,
    input  wire logic                      hba_rst,
    input  wire logic                      was_hba_rst,     // reset cause
    input  wire logic                      was_port_rst,
    input  wire logic [17:0]               pgm_ad,
    input  wire logic                      pgm_wa,
    input  wire logic                      pgm_wd,
    input  wire logic                      cominit_got,     // async jump request
    input  wire logic                      pcmd_st_cleared, // async jump request
    input  wire hba_fsm_pkg::port_status_t status,
    input  wire hba_fsm_pkg::fsm_done_t    done,
    output hba_fsm_pkg::fsm_actions_t      actions
);

    logic [PGM_AW-1:0]      rd_addr;
    logic                   rd_en;
    hba_fsm_pkg::pgm_word_u rd_word;
    logic                   cond_met;
    logic                   act_strobe;
    logic [5:0]             act_code;

    fsm_pgm_mem #(
        .PGM_AW (PGM_AW)
    ) fsm_pgm_mem_inst (
        .aclk    (aclk),
        .pgm_ad  (pgm_ad),
        .pgm_wa  (pgm_wa),
        .pgm_wd  (pgm_wd),
        .rd_addr (rd_addr),
        .rd_en   (rd_en),
        .rd_word (rd_word)
    );

    fsm_sequencer #(
        .PGM_AW (PGM_AW)
    ) fsm_sequencer_inst (
        .aclk            (aclk),
        .hba_rst         (hba_rst),
        .was_hba_rst     (was_hba_rst),
        .was_port_rst    (was_port_rst),
        .cominit_got     (cominit_got),
        .pcmd_st_cleared (pcmd_st_cleared),
        .done            (done),
        .rd_word         (rd_word),
        .cond_met        (cond_met),
        .rd_addr         (rd_addr),
        .rd_en           (rd_en),
        .act_strobe      (act_strobe),
        .act_code        (act_code)
    );

    fsm_cond_select fsm_cond_select_inst (
        .status   (status),
        .cond_sel (rd_word.trans.cond_sel),   // transition view of the current word
        .cond_met (cond_met)
    );

    fsm_action_decode fsm_action_decode_inst (
        .aclk       (aclk),
        .hba_rst    (hba_rst),
        .act_strobe (act_strobe),
        .act_code   (act_code),
        .actions    (actions)
    );

endmodule

`default_nettype wire

// ==== tb_ahci_port_fsm.sv ====
// replays ahci_port_fsm_golden.txt from the project root; run limit is 200 cycles per test
`timescale 1ns/10ps
`default_nettype none

module tb_ahci_port_fsm;

    logic                      aclk = 1'b0;
    logic                      hba_rst;
    logic                      was_hba_rst;
    logic                      was_port_rst;
    logic [17:0]               pgm_ad;
    logic                      pgm_wa;
    logic                      pgm_wd;
    logic                      cominit_got;
    logic                      pcmd_st_cleared;
    hba_fsm_pkg::port_status_t status;
    hba_fsm_pkg::fsm_done_t    done;
    hba_fsm_pkg::fsm_actions_t actions;

    int            seen_q[$];   // observed action codes in arrival order
    int            errors = 0;
    int            checks = 0;
    int            test_errs = 0;
    int            test_num = 1;
    int            limit = 0;   // 0 until the golden file is counted
    int            cycles = 0;
    int            fd;
    int            rc;
    string         tok;
    logic [31:0]   arg_a;
    logic [31:0]   arg_d;
    int            arg_n;
    logic [25:0]   arg_s;
    logic [1599:0] skip_line;
    int            n_tests;
    logic          eof_seen;
    logic          rst_seen = 1'b0;   // reset sampled on the previous edge

    always #4 aclk = ~aclk;     // 8 ns period

    ahci_port_fsm #(
        .PGM_AW (10)
    ) ahci_port_fsm_inst (
        .aclk            (aclk),
        .hba_rst         (hba_rst),
        .was_hba_rst     (was_hba_rst),
        .was_port_rst    (was_port_rst),
        .pgm_ad          (pgm_ad),
        .pgm_wa          (pgm_wa),
        .pgm_wd          (pgm_wd),
        .cominit_got     (cominit_got),
        .pcmd_st_cleared (pcmd_st_cleared),
        .status          (status),
        .done            (done),
        .actions         (actions)
    );

    // pulse monitor with code 1 on the msb of the struct
    always @(posedge aclk) begin : watch_actions
        logic [23:0] bits;
        int          code;
        bits = actions;
        code = 0;
        if (hba_rst && rst_seen) begin
            checks++;
            assert (bits == 24'h0) else begin
                $display("[FAIL] %0t actions: expected %h got %h", $time, 24'h0, bits);
                errors++;
                test_errs++;
            end
        end else if (bits != 24'h0) begin
            checks++;
            assert ($onehot(bits)) else begin
                $display("%0t: several action pulses at once, actions %h", $time, bits);
                errors++;
                test_errs++;
            end
            for (int i = 0; i < 24; i++) begin
                if (bits[i]) code = 24 - i;
            end
            seen_q.push_back(code);
        end
        rst_seen <= hba_rst;
    end

    always @(posedge aclk) begin
        if (limit > 0) begin
            cycles++;
            if (cycles > limit) begin
                $display("run stopped, no result after %0d cycles", limit);
                $display("tests failed");
                $finish;
            end
        end
    end

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
        @(posedge aclk);
        pgm_ad <= addr[17:0];
        pgm_wa <= 1'b1;
        @(posedge aclk);
        pgm_wa <= 1'b0;
        pgm_ad <= data[17:0];
        pgm_wd <= 1'b1;                  // write at pointer
        @(posedge aclk);
        pgm_wd <= 1'b0;
    endtask

    task automatic apply_reset(input int cause);
        @(posedge aclk);
        hba_rst      <= 1'b1;
        was_hba_rst  <= (cause == 1);
        was_port_rst <= (cause == 2);    // causes stay held after release
        repeat (8) @(posedge aclk);
        hba_rst <= 1'b0;
    endtask

    task automatic pulse_cominit();
        @(posedge aclk);
        cominit_got <= 1'b1;
        @(posedge aclk);
        cominit_got <= 1'b0;
    endtask

    task automatic pulse_st_cleared();
        @(posedge aclk);
        pcmd_st_cleared <= 1'b1;
        @(posedge aclk);
        pcmd_st_cleared <= 1'b0;
    endtask

    task automatic pulse_done();
        @(posedge aclk);
        done <= hba_fsm_pkg::fsm_done_t'(3'b010);   // get_fis_done
        @(posedge aclk);
        done <= '0;
    endtask

    task automatic expect_code(input int exp);
        int waited;
        int got;
        waited = 0;
        while (seen_q.size() == 0 && waited < 64) begin
            @(negedge aclk);
            waited++;
        end
        checks++;
        assert (seen_q.size() != 0) else begin
            $display("%0t: no action pulse within 64 cycles, code %0d expected", $time, exp);
            errors++;
            test_errs++;
        end
        if (seen_q.size() != 0) begin
            got = seen_q.pop_front();
            checks++;
            assert (got == exp) else begin
                $display("[FAIL] %0t action code: expected %0d got %0d", $time, exp, got);
                errors++;
                test_errs++;
            end
        end
    endtask

    task automatic check_quiet(input int n);
        repeat (n) @(negedge aclk);
        checks++;
        assert (seen_q.size() == 0) else begin
            $display("%0t: unexpected action pulse with code %0d", $time, seen_q[0]);
            errors++;
            test_errs++;
            seen_q.delete();
        end
    endtask

    task automatic finish_test();
        check_quiet(1);
        $display("test %0d done, %0d errors", test_num, test_errs);
        test_num++;
        test_errs = 0;
    endtask

    initial begin
        hba_rst         = 1'b1;
        was_hba_rst     = 1'b0;
        was_port_rst    = 1'b0;
        pgm_ad          = '0;
        pgm_wa          = 1'b0;
        pgm_wd          = 1'b0;
        cominit_got     = 1'b0;
        pcmd_st_cleared = 1'b0;
        status          = '0;
        done            = '0;

        fd = $fopen("ahci_port_fsm_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open ahci_port_fsm_golden.txt");
            $display("tests failed");
            $finish;
        end else begin
            n_tests  = 0;
            eof_seen = 1'b0;
            while (!eof_seen) begin              // first pass counts tests
                rc = $fscanf(fd, "%s", tok);
                if (rc != 1) eof_seen = 1'b1;
                else if (tok == "#") rc = $fgets(skip_line, fd);
                else if (tok == "T") n_tests++;
            end
            $fclose(fd);
            limit = 200 * n_tests;
            fd = $fopen("ahci_port_fsm_golden.txt", "r");
            eof_seen = 1'b0;
            while (!eof_seen) begin
                rc = $fscanf(fd, "%s", tok);
                if (rc != 1) begin
                    eof_seen = 1'b1;
                end else begin
                    case (tok)
                        "#": rc = $fgets(skip_line, fd);
                        "W": begin
                            rc = $fscanf(fd, "%h %h", arg_a, arg_d);
                            write_word(arg_a, arg_d);
                        end
                        "R": begin
                            rc = $fscanf(fd, "%d", arg_n);
                            apply_reset(arg_n);
                        end
                        "S": begin
                            rc = $fscanf(fd, "%h", arg_s);
                            @(posedge aclk);
                            status <= hba_fsm_pkg::port_status_t'(arg_s);
                        end
                        "C": pulse_cominit();
                        "X": pulse_st_cleared();
                        "D": pulse_done();
                        "E": begin
                            rc = $fscanf(fd, "%d", arg_n);
                            expect_code(arg_n);
                        end
                        "Q": begin
                            rc = $fscanf(fd, "%d", arg_n);
                            check_quiet(arg_n);
                        end
                        "T": finish_test();
                        default: begin
                            $display("unknown record %s in the golden file", tok);
                            errors++;
                        end
                    endcase
                end
            end
            $fclose(fd);
            $display("summary: %0d tests, %0d checks, %0d errors", n_tests, checks, errors);
            if (errors == 0) begin
                $display("all tests passed");
            end else begin
                $display("tests failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== ahci_port_fsm.f ====
hba_fsm_pkg.sv
fsm_pgm_mem.sv
fsm_cond_select.sv
fsm_action_decode.sv
fsm_sequencer.sv
ahci_port_fsm.sv
tb_ahci_port_fsm.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the ahci_port_fsm testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f ahci_port_fsm.f --top-module tb_ahci_port_fsm -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "tests failed" sim.log; then
    exit 1
fi
if ! grep -q "all tests passed" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

// ==== ahci_port_fsm_golden.txt ====
# records: W addr(hex) data(hex) | R cause(0 por,1 hba,2 port) | S status(hex) | C | X | D
# E code(dec) next pulse | Q n(dec) no pulse for n cycles | T end of test
# test 1 power-on entry, zero memory halts
R 0 Q 50 T
# test 2 hba reset entry, pulse order, done wait
W 2 20001 W 3 00010 W 10 00002 W 11 10003 W 12 00004 W 13 00000
R 1 E 1 E 2 E 3 Q 10 D E 4 Q 30 T
# test 3 conditions, fall through, d2hr jump, code above 24, closing wrap
W 2 20005 W 3 01c28 W 4 00c20 W 20 00019 W 21 00006 W 22 20007
W 23 00030 W 30 20008 W 31 04000 W 32 20000
S 4d00 R 1 E 5 E 6 E 7 E 8 Q 30 T
# test 4 cominit abandons a done wait
S 0 W 2 30009 W 6 2000a W 7 00013
R 1 E 9 Q 10 C E 10 D Q 30 T
# test 5 port reset entry, then st_cleared jump
W 4 2000b W 5 00013 W 8 2000c W 9 00013
R 2 E 11 Q 20 X E 12 Q 20 T
# test 6 reset during a done wait stays silent
R 1 E 9 R 0 Q 40 T
